/* irq_ctrl.f */
+incdir+include
verilog/irq_ctrl_pkg.sv
verilog/irq_axil_regs.sv
verilog/irq_arbiter.sv
verilog/wfi_sleep_ctrl.sv
verilog/irq_ctrl_top.sv
testbench/tb_irq_ctrl.sv

/* Makefile */
# Verilator build and run of the interrupt controller testbench

SIM  := obj_dir/Vtb_irq_ctrl
SRCS := $(shell grep -v '^+' irq_ctrl.f) include/tb_irq_ctrl_tasks.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(SIM): $(SRCS) irq_ctrl.f
	verilator --binary --timing --assert -f irq_ctrl.f \
	  --top-module tb_irq_ctrl -Mdir obj_dir

# Pass or fail comes from the log, not from the exit code of the binary
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/tb_irq_ctrl_tasks.svh */
// ----------------------------------------
// Bus and interrupt stimulus tasks of the interrupt controller testbench
// Included inside the testbench module
// All tasks start and end 1 ns after an edge
// ----------------------------------------
`ifndef TB_IRQ_CTRL_TASKS_SVH
`define TB_IRQ_CTRL_TASKS_SVH

// Advance to 1 ns after the n-th next rising edge
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  #1;
endtask

// ----------------------------------------
// AXI4-Lite manager
// ----------------------------------------
task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                         input axil_resp_e exp_resp);
  int cnt;
  cnt = 0;
  axil_req.aw_addr = addr;
  axil_req.aw_valid = 1'b1;
  axil_req.w_data = data;
  axil_req.w_strb = 4'hF;
  axil_req.w_valid = 1'b1;
  axil_req.b_ready = 1'b1;
  // Ready seen now means the handshake lands on the next edge
  while (!axil_rsp.aw_ready) begin
    assert (cnt < BUS_TIMEOUT) else stop_with_failure("AXI4-Lite write was never accepted");
    cnt++;
    wait_cycles(1);
  end
  wait_cycles(1);
  axil_req.aw_valid = 1'b0;
  axil_req.w_valid = 1'b0;
  assert (axil_rsp.b_valid) else stop_with_failure("No write response after the handshake");
  check_value("b_resp", 32'(axil_rsp.b_resp), 32'(exp_resp));
  wait_cycles(1);
  axil_req.b_ready = 1'b0;
endtask

task automatic read_check(input logic [3:0] addr, input string name,
                          input logic [31:0] expected);
  int cnt;
  cnt = 0;
  axil_req.ar_addr = addr;
  axil_req.ar_valid = 1'b1;
  axil_req.r_ready = 1'b1;
  while (!axil_rsp.ar_ready) begin
    assert (cnt < BUS_TIMEOUT) else stop_with_failure("AXI4-Lite read was never accepted");
    cnt++;
    wait_cycles(1);
  end
  wait_cycles(1);
  axil_req.ar_valid = 1'b0;
  assert (axil_rsp.r_valid) else stop_with_failure("No read data after the handshake");
  check_value({name, " r_resp"}, 32'(axil_rsp.r_resp), 32'(RESP_OKAY));
  check_value(name, axil_rsp.r_data, expected);
  wait_cycles(1);
  axil_req.r_ready = 1'b0;
endtask

// ----------------------------------------
// Interrupt and core stimulus
// ----------------------------------------
task automatic drive_random_irq();
  logic [31:0] r;
  r = $random(seed);
  // Half the words keep only the low lines, so 11, 3 and 7 get to win
  if (r[0]) begin
    irq_i = r & 32'h0000_FFFF;
  end else begin
    irq_i = r;
  end
endtask

task automatic pulse_ack();
  irq_ack = 1'b1;
  wait_cycles(1);
  irq_ack = 1'b0;
endtask

task automatic pulse_mret();
  mret = 1'b1;
  wait_cycles(1);
  mret = 1'b0;
endtask

task automatic pulse_wfi();
  wfi = 1'b1;
  wait_cycles(1);
  wfi = 1'b0;
endtask

`endif

/* testbench/tb_irq_ctrl.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Testbench of the interrupt controller
// Mirror model with an offer check every cycle plus directed CSR, take and WFI tests
// ----------------------------------------
module tb_irq_ctrl
  import irq_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  // Cycle budget of the whole sequence with margin
  localparam int TEST_CYCLES = 600;
  localparam int BUS_TIMEOUT = 20;

  logic        clk_i;
  logic        rst_ni;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic [31:0] irq_i;
  irq_req_t    irq_req;
  logic        irq_ack;
  logic        mret;
  logic        wfi;
  logic        pipeline_idle;
  logic        debug_req;
  logic        core_sleep;
  integer      seed;

  // Mirror of the CSR state
  logic [31:0] exp_mip;
  logic [31:0] exp_mie;
  logic        exp_mstatus_mie;
  logic        exp_mpie;
  logic [31:0] exp_mcause;
  logic        exp_bvalid;

  irq_ctrl_top #(
    .WFI_SLEEP_LATENCY (2)
  ) i_irq_ctrl_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .axil_req_i      (axil_req),
    .axil_rsp_o      (axil_rsp),
    .irq_i           (irq_i),
    .irq_req_o       (irq_req),
    .irq_ack_i       (irq_ack),
    .mret_i          (mret),
    .wfi_i           (wfi),
    .pipeline_idle_i (pipeline_idle),
    .debug_req_i     (debug_req),
    .core_sleep_o    (core_sleep)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else stop_with_failure($sformatf(
      "[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, expected));
  endtask

  `include "tb_irq_ctrl_tasks.svh"

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Winner by fixed order 31..16, 11, 3, 7
  // Offered only with MIE set
  function automatic irq_req_t ref_winner(input logic [31:0] mip, input logic [31:0] mie,
                                          input logic gie);
    logic [31:0] act;
    irq_req_t    res;
    act = mip & mie;
    res = '0;
    for (int i = 31; i >= 16; i--) begin
      if (act[i] && !res.valid) begin
        res.valid = 1'b1;
        res.id = 5'(i);
      end
    end
    if (!res.valid && act[11]) begin
      res = '{valid: 1'b1, id: 5'd11};
    end else if (!res.valid && act[3]) begin
      res = '{valid: 1'b1, id: 5'd3};
    end else if (!res.valid && act[7]) begin
      res = '{valid: 1'b1, id: 5'd7};
    end
    res.valid = res.valid & gie;
    return res;
  endfunction

  // Mirror follows the inputs at each edge
  // Take first, then mret, then bus write
  always @(posedge clk_i or negedge rst_ni) begin : mirror_csr
    irq_req_t offer;
    logic     wr_hs;
    if (!rst_ni) begin
      exp_mip = '0;
      exp_mie = '0;
      exp_mstatus_mie = 1'b0;
      exp_mpie = 1'b0;
      exp_mcause = '0;
      exp_bvalid = 1'b0;
    end else begin
      offer = ref_winner(exp_mip, exp_mie, exp_mstatus_mie);
      wr_hs = axil_req.aw_valid && axil_req.w_valid && !exp_bvalid;
      if (wr_hs && axil_req.aw_addr == REG_MIE) begin
        exp_mie = axil_req.w_data & VALID_IRQ_MASK;
      end
      if (offer.valid && irq_ack) begin
        exp_mpie = exp_mstatus_mie;
        exp_mstatus_mie = 1'b0;
        exp_mcause = {1'b1, 26'b0, offer.id};
      end else if (mret) begin
        exp_mstatus_mie = exp_mpie;
        exp_mpie = 1'b1;
      end else if (wr_hs && axil_req.aw_addr == REG_MSTATUS) begin
        exp_mstatus_mie = axil_req.w_data[3];
        exp_mpie = axil_req.w_data[7];
      end
      if (wr_hs) begin
        exp_bvalid = 1'b1;
      end else if (axil_req.b_ready) begin
        exp_bvalid = 1'b0;
      end
      exp_mip = irq_i & VALID_IRQ_MASK;
    end
  end

  // Offer compared mid-cycle
  // Id only matters while valid
  always @(negedge clk_i) begin : compare_offer
    irq_req_t exp;
    if (rst_ni) begin
      exp = ref_winner(exp_mip, exp_mie, exp_mstatus_mie);
      check_value("irq_req_o.valid", 32'(irq_req.valid), 32'(exp.valid));
      if (exp.valid) begin
        check_value("irq_req_o.id", 32'(irq_req.id), 32'(exp.id));
      end
    end
  end

  initial begin : watchdog
    #(TEST_CYCLES * CLK_PERIOD * 2);
    stop_with_failure("Watchdog expired, the test sequence did not finish in time");
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : run_tests
    logic [31:0] mie_val;
    seed = 32'h055b872b;
    axil_req = '0;
    irq_i = '0;
    irq_ack = 1'b0;
    mret = 1'b0;
    wfi = 1'b0;
    pipeline_idle = 1'b1;
    debug_req = 1'b0;
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_cycles(1);

    // Register access with reserved mie bits reading as zero
    write_reg(REG_MIE, 32'hFFFF_FFFF, RESP_OKAY);
    read_check(REG_MIE, "mie", 32'hFFFF_0888);
    write_reg(REG_MSTATUS, 32'h0000_0008, RESP_OKAY);
    read_check(REG_MSTATUS, "mstatus", 32'h0000_0008);
    write_reg(REG_MSTATUS, 32'h0000_0000, RESP_OKAY);
    read_check(REG_MSTATUS, "mstatus", 32'h0000_0000);
    write_reg(REG_MCAUSE, 32'h1234_5678, RESP_OKAY);
    read_check(REG_MCAUSE, "mcause", exp_mcause);
    write_reg(4'h6, 32'h1234_5678, RESP_SLVERR);

    // A held write response stalls the next write
    axil_req.aw_addr = REG_MIE;
    axil_req.w_data = 32'h0001_0800;
    axil_req.w_strb = 4'hF;
    axil_req.aw_valid = 1'b1;
    axil_req.w_valid = 1'b1;
    wait_cycles(1);
    axil_req.w_data = 32'h0002_0008;
    repeat (3) begin
      check_value("b_valid", 32'(axil_rsp.b_valid), 32'd1);
      check_value("aw_ready", 32'(axil_rsp.aw_ready), 32'd0);
      check_value("w_ready", 32'(axil_rsp.w_ready), 32'd0);
      wait_cycles(1);
    end
    read_check(REG_MIE, "mie", 32'h0001_0800);
    write_reg(REG_MIE, 32'h0002_0008, RESP_OKAY);
    read_check(REG_MIE, "mie", 32'h0002_0008);

    // Pending sampling
    repeat (8) begin
      drive_random_irq();
      wait_cycles(1);
      read_check(REG_MIP, "mip", irq_i & VALID_IRQ_MASK);
    end

    // Arbitration against the reference with global enable on
    write_reg(REG_MSTATUS, 32'h0000_0008, RESP_OKAY);
    repeat (6) begin
      mie_val = $random(seed);
      write_reg(REG_MIE, mie_val, RESP_OKAY);
      repeat (50) begin
        drive_random_irq();
        wait_cycles(1);
      end
    end
    // Global enable off
    write_reg(REG_MSTATUS, 32'h0000_0000, RESP_OKAY);
    repeat (40) begin
      drive_random_irq();
      wait_cycles(1);
      check_value("irq_req_o.valid", 32'(irq_req.valid), 32'd0);
    end

    // Take and return where line 20 beats line 11
    write_reg(REG_MIE, 32'h0010_0800, RESP_OKAY);
    irq_i = 32'h0010_0800;
    write_reg(REG_MSTATUS, 32'h0000_0008, RESP_OKAY);
    check_value("irq_req_o.id", 32'(irq_req.id), 32'd20);
    pulse_ack();
    check_value("irq_req_o.valid", 32'(irq_req.valid), 32'd0);
    read_check(REG_MSTATUS, "mstatus", 32'h0000_0080);
    read_check(REG_MCAUSE, "mcause", exp_mcause);
    pulse_mret();
    check_value("irq_req_o.valid", 32'(irq_req.valid), 32'd1);
    read_check(REG_MSTATUS, "mstatus", 32'h0000_0088);

    // WFI with idle pipeline while MIE is off and only line 16 is enabled
    write_reg(REG_MSTATUS, 32'h0000_0000, RESP_OKAY);
    write_reg(REG_MIE, 32'h0001_0000, RESP_OKAY);
    irq_i = '0;
    wait_cycles(2);
    pulse_wfi();
    check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd1);
    // Enabled pending line wakes even with MIE off
    irq_i = 32'h0001_0000;
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd1);
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    irq_i = '0;
    wait_cycles(2);

    // Busy pipeline holds off sleep until idle
    pipeline_idle = 1'b0;
    pulse_wfi();
    repeat (4) begin
      wait_cycles(1);
      check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    end
    pipeline_idle = 1'b1;
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd1);
    // Debug request wakes
    debug_req = 1'b1;
    wait_cycles(1);
    check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    debug_req = 1'b0;
    wait_cycles(1);

    // Pending line disabled in mie leaves the core asleep
    irq_i = 32'h0010_0000;
    wait_cycles(1);
    pulse_wfi();
    wait_cycles(2);
    repeat (5) begin
      check_value("core_sleep_o", 32'(core_sleep), 32'd1);
      wait_cycles(1);
    end
    irq_i = '0;

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* verilog/irq_ctrl_top.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Machine-mode interrupt controller top level
// Register port, arbiter and WFI sleep controller
// ----------------------------------------
module irq_ctrl_top
  import irq_ctrl_pkg::*;
#(
  parameter int unsigned WFI_SLEEP_LATENCY = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  axil_req_t          axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  input  logic [NUM_IRQ-1:0] irq_i,
  output irq_req_t           irq_req_o,
  input  logic               irq_ack_i,
  input  logic               mret_i,
  input  logic               wfi_i,
  input  logic               pipeline_idle_i,
  input  logic               debug_req_i,
  output logic               core_sleep_o
);

  // Internal links
  irq_cfg_t           cfg;
  irq_take_t          take;
  logic [NUM_IRQ-1:0] mip;
  logic               wake_pending;

  // ----------------------------------------
  // CSRs behind AXI4-Lite
  // ----------------------------------------
  irq_axil_regs i_irq_axil_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .mip_i      (mip),
    .take_i     (take),
    .mret_i     (mret_i),
    .cfg_o      (cfg)
  );

  // Pending, priority and offer
  irq_arbiter i_irq_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .irq_i          (irq_i),
    .cfg_i          (cfg),
    .irq_ack_i      (irq_ack_i),
    .irq_req_o      (irq_req_o),
    .take_o         (take),
    .mip_o          (mip),
    .wake_pending_o (wake_pending)
  );

  // Sleep and wake
  wfi_sleep_ctrl #(
    .WFI_SLEEP_LATENCY (WFI_SLEEP_LATENCY)
  ) i_wfi_sleep_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wfi_i           (wfi_i),
    .pipeline_idle_i (pipeline_idle_i),
    .debug_req_i     (debug_req_i),
    .wake_pending_i  (wake_pending),
    .core_sleep_o    (core_sleep_o)
  );

endmodule

/* verilog/wfi_sleep_ctrl.sv */
`timescale 1ns/1ps
// ----------------------------------------
// WFI sleep controller
// Drains the pipeline after a retired WFI, then holds the core asleep
// ----------------------------------------
module wfi_sleep_ctrl
  import irq_ctrl_pkg::*;
#(
  parameter int unsigned WFI_SLEEP_LATENCY = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_i,
  input  logic pipeline_idle_i,
  input  logic debug_req_i,
  input  logic wake_pending_i,
  output logic core_sleep_o
);

  // Counter holds up to WFI_SLEEP_LATENCY-1
  localparam int unsigned CNT_W = (WFI_SLEEP_LATENCY > 1) ? $clog2(WFI_SLEEP_LATENCY) : 1;
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(WFI_SLEEP_LATENCY - 1);

  wfi_state_e       state_q;
  wfi_state_e       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             wake;
  logic             core_sleep_q;

  assign wake = wake_pending_i | debug_req_i;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d = cnt_q;
    case (state_q)
      WFI_RUN: begin
        // A WFI that meets a wake just retires
        if (wfi_i && !wake) begin
          state_d = WFI_DRAIN;
          cnt_d = CNT_INIT;
        end
      end
      WFI_DRAIN: begin
        if (wake) begin
          state_d = WFI_RUN;
        end else if (cnt_q != '0) begin
          cnt_d = cnt_q - 1'b1;
        end else if (pipeline_idle_i) begin
          state_d = WFI_SLEEP;
        end
      end
      WFI_SLEEP: begin
        if (wake) begin
          state_d = WFI_RUN;
        end
      end
      default: state_d = WFI_RUN;
    endcase
  end

  // ----------------------------------------
  // State registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_RUN;
      cnt_q <= '0;
      core_sleep_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q <= cnt_d;
      core_sleep_q <= (state_d == WFI_SLEEP);
    end
  end

  // Glitch-free sleep output
  assign core_sleep_o = core_sleep_q;

endmodule

/* verilog/irq_arbiter.sv */
`timescale 1ns/1ps
// ----------------------------------------
// Pending register and fixed-priority interrupt selection
// Offers the winner to the core and flags the take back to the CSRs
// ----------------------------------------
module irq_arbiter
  import irq_ctrl_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  irq_cfg_t           cfg_i,
  input  logic               irq_ack_i,
  output irq_req_t           irq_req_o,
  output irq_take_t          take_o,
  output logic [NUM_IRQ-1:0] mip_o,
  output logic               wake_pending_o
);

  logic [NUM_IRQ-1:0]  mip_q;
  logic [NUM_IRQ-1:0]  pend_en;
  logic                any_pend;
  logic [IRQ_ID_W-1:0] win_id;
  logic                offer;

  // ----------------------------------------
  // Pending sampling
  // ----------------------------------------
  // Reserved lines never pend
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // Enabled and pending before the global enable
  assign pend_en = mip_q & cfg_i.mie;
  assign any_pend = |pend_en;

  // Wake ignores mstatus MIE
  assign wake_pending_o = any_pend;

  // ----------------------------------------
  // Priority select
  // ----------------------------------------
  // Order is 31..16, then 11 (MEI), 3 (MSI), 7 (MTI)
  // Written lowest first so a later match overrides
  always_comb begin
    win_id = '0;
    if (pend_en[7]) begin
      win_id = IRQ_ID_W'(7);
    end
    if (pend_en[3]) begin
      win_id = IRQ_ID_W'(3);
    end
    if (pend_en[11]) begin
      win_id = IRQ_ID_W'(11);
    end
    // Highest platform line wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_id = IRQ_ID_W'(i);
      end
    end
  end

  // ----------------------------------------
  // Offer and take
  // ----------------------------------------
  assign offer = any_pend & cfg_i.mstatus_mie;

  assign irq_req_o = '{valid: offer, id: win_id};

  // Taken in any cycle where offer and ack meet
  assign take_o = '{take: offer & irq_ack_i, id: win_id};

endmodule

/* verilog/irq_axil_regs.sv */
`timescale 1ns/1ps
// ----------------------------------------
// AXI4-Lite register block of the interrupt controller
// Stores mie, mstatus MIE and MPIE and mcause and reads back mip
// ----------------------------------------
module irq_axil_regs
  import irq_ctrl_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  axil_req_t          axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  input  logic [NUM_IRQ-1:0] mip_i,
  input  irq_take_t          take_i,
  input  logic               mret_i,
  output irq_cfg_t           cfg_o
);

  // CSR state
  logic [NUM_IRQ-1:0]     mie_q;
  logic                   mstatus_mie_q;
  logic                   mstatus_mpie_q;
  logic                   mcause_irq_q;
  logic [IRQ_ID_W-1:0]    mcause_id_q;

  // Response channel state
  logic                   b_valid_q;
  axil_resp_e             b_resp_q;
  logic                   r_valid_q;
  axil_resp_e             r_resp_q;
  logic [AXIL_DATA_W-1:0] r_data_q;

  // Decode
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   wr_mie;
  logic                   wr_mstatus;
  axil_resp_e             wr_resp;
  logic [AXIL_DATA_W-1:0] mstatus_rd;
  logic [AXIL_DATA_W-1:0] wr_data_mie;
  logic [AXIL_DATA_W-1:0] wr_data_mstatus;
  logic [AXIL_DATA_W-1:0] rd_data;
  axil_resp_e             rd_resp;

  // Merge write data into the old value byte by byte
  function automatic logic [AXIL_DATA_W-1:0] apply_strb(
    input logic [AXIL_DATA_W-1:0]   old_val,
    input logic [AXIL_DATA_W-1:0]   new_val,
    input logic [AXIL_DATA_W/8-1:0] strb
  );
    logic [AXIL_DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < AXIL_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // Handshakes and address decode
  // ----------------------------------------
  // AW and W go together with one write in flight
  assign wr_hs = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign rd_hs = axil_req_i.ar_valid & ~r_valid_q;

  always_comb begin
    mstatus_rd = '0;
    mstatus_rd[MSTATUS_MIE_BIT] = mstatus_mie_q;
    mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  assign wr_data_mie = apply_strb(mie_q, axil_req_i.w_data, axil_req_i.w_strb) & VALID_IRQ_MASK;
  assign wr_data_mstatus = apply_strb(mstatus_rd, axil_req_i.w_data, axil_req_i.w_strb);

  always_comb begin
    wr_mie = 1'b0;
    wr_mstatus = 1'b0;
    wr_resp = RESP_OKAY;
    case (axil_req_i.aw_addr)
      REG_MIE:     wr_mie = wr_hs;
      REG_MSTATUS: wr_mstatus = wr_hs;
      // Read-only registers silently drop the write
      REG_MIP, REG_MCAUSE: wr_resp = RESP_OKAY;
      default:     wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (axil_req_i.ar_addr)
      REG_MIE:     rd_data = mie_q;
      REG_MSTATUS: rd_data = mstatus_rd;
      REG_MIP:     rd_data = mip_i;
      REG_MCAUSE:  rd_data = {mcause_irq_q, {(AXIL_DATA_W-1-IRQ_ID_W){1'b0}}, mcause_id_q};
      default:     rd_resp = RESP_SLVERR;
    endcase
  end

  // ----------------------------------------
  // CSR update
  // ----------------------------------------
  // Take beats mret and mret beats a bus write to mstatus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
      mstatus_mie_q <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mcause_irq_q <= 1'b0;
      mcause_id_q <= '0;
    end else begin
      if (wr_mie) begin
        mie_q <= wr_data_mie;
      end
      if (take_i.take) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q <= 1'b0;
        mcause_irq_q <= 1'b1;
        mcause_id_q <= take_i.id;
      end else if (mret_i) begin
        mstatus_mie_q <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end else if (wr_mstatus) begin
        mstatus_mie_q <= wr_data_mstatus[MSTATUS_MIE_BIT];
        mstatus_mpie_q <= wr_data_mstatus[MSTATUS_MPIE_BIT];
      end
    end
  end

  // ----------------------------------------
  // Response channels
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      // Valid holds until the manager is ready
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_resp_q <= RESP_OKAY;
      r_data_q <= '0;
      r_resp_q <= RESP_OKAY;
    end else begin
      if (wr_hs) begin
        b_resp_q <= wr_resp;
      end
      if (rd_hs) begin
        r_data_q <= rd_data;
        r_resp_q <= rd_resp;
      end
    end
  end

  assign axil_rsp_o = '{
    aw_ready: ~b_valid_q,
    w_ready:  ~b_valid_q,
    b_resp:   b_resp_q,
    b_valid:  b_valid_q,
    ar_ready: ~r_valid_q,
    r_data:   r_data_q,
    r_resp:   r_resp_q,
    r_valid:  r_valid_q
  };

  assign cfg_o = '{mie: mie_q, mstatus_mie: mstatus_mie_q};

endmodule

/* verilog/irq_ctrl_pkg.sv */
// ----------------------------------------
// Shared constants, register map and types of the interrupt controller
// Imported by every RTL unit and by the testbench
// ----------------------------------------
package irq_ctrl_pkg;

  // Interrupt line layout
  localparam int NUM_IRQ = 32;
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hFFFF_0888;
  localparam int IRQ_ID_W = 5;

  // AXI4-Lite port sizes
  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  // Global enable bit positions inside mstatus
  localparam int MSTATUS_MIE_BIT = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  // ----------------------------------------
  // Enums
  // ----------------------------------------
  typedef enum logic [AXIL_ADDR_W-1:0] {
    REG_MIE     = 4'h0,
    REG_MSTATUS = 4'h4,
    REG_MIP     = 4'h8,
    REG_MCAUSE  = 4'hC
  } reg_addr_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic [1:0] {
    WFI_RUN,
    WFI_DRAIN,
    WFI_SLEEP
  } wfi_state_e;

  // ----------------------------------------
  // Packed bundles
  // ----------------------------------------
  // Manager side of the register port
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0]   aw_addr;
    logic                     aw_valid;
    logic [AXIL_DATA_W-1:0]   w_data;
    logic [AXIL_DATA_W/8-1:0] w_strb;
    logic                     w_valid;
    logic                     b_ready;
    logic [AXIL_ADDR_W-1:0]   ar_addr;
    logic                     ar_valid;
    logic                     r_ready;
  } axil_req_t;

  // Subordinate side of the register port
  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    axil_resp_e             b_resp;
    logic                   b_valid;
    logic                   ar_ready;
    logic [AXIL_DATA_W-1:0] r_data;
    axil_resp_e             r_resp;
    logic                   r_valid;
  } axil_rsp_t;

  // Offer to the core
  typedef struct packed {
    logic                valid;
    logic [IRQ_ID_W-1:0] id;
  } irq_req_t;

  // Accepted offer, back to the CSRs
  typedef struct packed {
    logic                take;
    logic [IRQ_ID_W-1:0] id;
  } irq_take_t;

  // Enable state seen by the arbiter
  typedef struct packed {
    logic [NUM_IRQ-1:0] mie;
    logic               mstatus_mie;
  } irq_cfg_t;

endpackage
